// File: Bender.yml
package:
  name: tag_store

sources:
  - files:
      - verilog/tag_store_pkg.sv
      - verilog/tag_req_ctrl.sv
      - verilog/tag_way_array.sv
      - verilog/tag_victim_select.sv
      - verilog/tag_resp_reg.sv
      - verilog/tag_store_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tag_store_assertions.sv
      - test/tag_store_tb.sv

// File: sim.f
verilog/tag_store_pkg.sv
verilog/tag_req_ctrl.sv
verilog/tag_way_array.sv
verilog/tag_victim_select.sv
verilog/tag_resp_reg.sv
verilog/tag_store_top.sv
test/tb_clock_gen.sv
test/tag_store_assertions.sv
test/tag_store_tb.sv

// File: test/tag_store_assertions.sv
`timescale 1ns/1ps

module tag_store_assertions (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic                     req_ready_i,
  input logic                     res_valid_i,
  input logic                     res_ready_i,
  input logic                     res_hit_i,
  input logic                     res_evict_i,
  input tag_store_pkg::way_mask_t res_way_i,
  input tag_store_pkg::tag_t      res_tag_i
);

  // Number of failed assertions so far
  int unsigned fail_cnt = 0;

  // Pending response holds valid and every field until taken
  a_resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (res_valid_i && !res_ready_i) |=>
      (res_valid_i && $stable({res_hit_i, res_evict_i, res_way_i, res_tag_i})))
    else begin
      $error("response changed before the handshake");
      fail_cnt++;
    end

  // Way output is one-hot, or zero when nothing was eligible
  a_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(res_way_i))
    else begin
      $error("res_way_o has more than one bit set");
      fail_cnt++;
    end

  // No new request while a response is outstanding
  a_no_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_i |-> !req_ready_i)
    else begin
      $error("req_ready_o high while res_valid_o is high");
      fail_cnt++;
    end

endmodule

bind tag_store_top tag_store_assertions u_assertions (
  .clk_i, .rst_n_i,
  .req_ready_i (req_ready_o), .res_valid_i (res_valid_o), .res_ready_i,
  .res_hit_i (res_hit_o), .res_evict_i (res_evict_o),
  .res_way_i (res_way_o), .res_tag_i (res_evict_tag_o)
);

// File: test/tag_store_tb.sv
`timescale 1ns/1ps

module tag_store_tb;

  localparam int unsigned SEED           = 32'h404a_abf9;
  localparam int          NUM_OPS        = 400;
  localparam int          MAX_GAP        = 20;
  localparam int          TIMEOUT_CYCLES = NUM_OPS * (MAX_GAP + 5) + 100;
  // Accept edge counts as the first, the response register loads on the next
  localparam int          RESP_EDGES     = 2;

  logic clk;
  logic rst_n;
  logic req_valid;
  logic req_ready;
  logic req_dirty;
  logic res_valid;
  logic res_ready;
  logic res_hit;
  logic res_evict;
  tag_store_pkg::tag_op_e    req_op;
  tag_store_pkg::index_t     req_index;
  tag_store_pkg::tag_t       req_tag;
  tag_store_pkg::tag_t       res_evict_tag;
  tag_store_pkg::way_mask_t  req_way_mask;
  tag_store_pkg::way_mask_t  spm_lock;
  tag_store_pkg::way_mask_t  res_way;

  // Reference model state
  tag_store_pkg::tag_line_t model_mem [tag_store_pkg::NUM_WAYS][tag_store_pkg::NUM_SETS];
  int rr_ptr;
  logic exp_hit;
  logic exp_evict;
  tag_store_pkg::way_mask_t exp_way;
  tag_store_pkg::tag_t      exp_tag;

  int op_count;
  int cycle_count;
  tag_store_pkg::tag_op_e   rnd_op;
  tag_store_pkg::way_mask_t rnd_mask;
  tag_store_pkg::way_mask_t rnd_lock;

  tb_clock_gen u_clk (.clk_o (clk), .rst_n_o (rst_n));

  tag_store_top UUT (
    .clk_i (clk), .rst_n_i (rst_n),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_op_i (req_op),
    .req_index_i (req_index), .req_tag_i (req_tag), .req_dirty_i (req_dirty),
    .req_way_mask_i (req_way_mask), .spm_lock_i (spm_lock),
    .res_valid_o (res_valid), .res_ready_i (res_ready), .res_hit_o (res_hit),
    .res_evict_o (res_evict), .res_way_o (res_way), .res_evict_tag_o (res_evict_tag)
  );

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("TB FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic compare_response();
    check_value("res_valid_o", res_valid, 1'b1);
    check_value("req_ready_o", req_ready, 1'b0);
    check_value("res_hit_o", res_hit, exp_hit);
    check_value("res_evict_o", res_evict, exp_evict);
    check_value("res_way_o", res_way, exp_way);
    check_value("res_evict_tag_o", res_evict_tag, exp_tag);
  endtask

  // Expected response and model update for one accepted request
  task automatic model_op(input tag_store_pkg::tag_op_e op, input int idx,
                          input tag_store_pkg::tag_t tag, input logic dirty,
                          input tag_store_pkg::way_mask_t mask,
                          input tag_store_pkg::way_mask_t lock);
    tag_store_pkg::way_mask_t elig;
    int hit_w;
    int vic_w;
    int c;
    exp_hit   = 1'b0;
    exp_evict = 1'b0;
    exp_way   = '0;
    exp_tag   = '0;
    hit_w     = -1;
    vic_w     = -1;
    elig      = mask & ~lock;
    if (op == tag_store_pkg::OP_FLUSH) begin
      // Flush ignores the lock and clears the named line
      for (int w = 0; w < tag_store_pkg::NUM_WAYS; w++) begin
        if (mask[w]) begin
          exp_way           = mask;
          exp_evict         = model_mem[w][idx].valid & model_mem[w][idx].dirty;
          exp_tag           = model_mem[w][idx].tag;
          model_mem[w][idx] = '0;
        end
      end
    end else begin
      for (int w = 0; w < tag_store_pkg::NUM_WAYS; w++) begin
        if (hit_w < 0 && elig[w] && model_mem[w][idx].valid && model_mem[w][idx].tag == tag)
          hit_w = w;
      end
      if (hit_w >= 0) begin
        exp_hit = 1'b1;
        exp_way = 4'b0001 << hit_w;
        if (dirty) model_mem[hit_w][idx].dirty = 1'b1;
      end else if (elig != '0) begin
        // Lowest invalid eligible way first
        for (int w = 0; w < tag_store_pkg::NUM_WAYS; w++) begin
          if (vic_w < 0 && elig[w] && !model_mem[w][idx].valid) vic_w = w;
        end
        if (vic_w < 0) begin
          for (int k = 0; k < tag_store_pkg::NUM_WAYS; k++) begin
            c = (rr_ptr + k) % tag_store_pkg::NUM_WAYS;
            if (vic_w < 0 && elig[c]) vic_w = c;
          end
          rr_ptr = (vic_w + 1) % tag_store_pkg::NUM_WAYS;
        end
        exp_way   = 4'b0001 << vic_w;
        exp_evict = model_mem[vic_w][idx].valid & model_mem[vic_w][idx].dirty;
        exp_tag   = model_mem[vic_w][idx].valid ? model_mem[vic_w][idx].tag : '0;
        model_mem[vic_w][idx] = '{valid: 1'b1, dirty: dirty, tag: tag};
      end
    end
  endtask

  // One request through accept, response, back-pressure and handshake
  task automatic run_op(input tag_store_pkg::tag_op_e op, input int idx,
                        input tag_store_pkg::tag_t tag, input logic dirty,
                        input tag_store_pkg::way_mask_t mask,
                        input tag_store_pkg::way_mask_t lock);
    int edges;
    int gap;
    model_op(op, idx, tag, dirty, mask, lock);
    req_valid    = 1'b1;
    req_op       = op;
    req_index    = idx;
    req_tag      = tag;
    req_dirty    = dirty;
    req_way_mask = mask;
    spm_lock     = lock;
    while (!req_ready) begin
      @(posedge clk);
      #2;
    end
    // Ready is stable here, so the coming edge is the accept edge
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    edges     = 1;
    while (!res_valid) begin
      @(posedge clk);
      #2;
      edges++;
    end
    check_value("res_valid_o latency", edges, RESP_EDGES);
    compare_response();
    gap = ($urandom % 2) ? 0 : $urandom % (MAX_GAP + 1);
    repeat (gap) begin
      @(posedge clk);
      #2;
      compare_response();
    end
    res_ready = 1'b1;
    @(posedge clk);
    #2;
    res_ready = 1'b0;
    check_value("res_valid_o", res_valid, 1'b0);
    check_value("req_ready_o", req_ready, 1'b1);
    op_count++;
  endtask

  // Hang guard
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run hung after %0d cycles", cycle_count);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  // A failed bound assertion ends the run
  always @(posedge clk) begin
    if (UUT.u_assertions.fail_cnt != 0) begin
      $display("A bound assertion failed on the DUT outputs");
      $display("TB FAILED");
      $fatal(1, "assertion failure");
    end
  end

  initial begin
    void'($urandom(SEED));
    req_valid    = 1'b0;
    req_op       = tag_store_pkg::OP_LOOKUP;
    req_index    = '0;
    req_tag      = '0;
    req_dirty    = 1'b0;
    req_way_mask = '0;
    spm_lock     = '0;
    res_ready    = 1'b0;
    rr_ptr       = 0;
    op_count     = 0;
    cycle_count  = 0;
    for (int w = 0; w < tag_store_pkg::NUM_WAYS; w++)
      for (int s = 0; s < tag_store_pkg::NUM_SETS; s++)
        model_mem[w][s] = '0;
    @(posedge rst_n);
    check_value("res_valid_o", res_valid, 1'b0);
    check_value("req_ready_o", req_ready, 1'b1);

    // Fill an empty set, then hit
    run_op(tag_store_pkg::OP_LOOKUP, 3, 8'h11, 1'b0, 4'hF, 4'h0);
    run_op(tag_store_pkg::OP_LOOKUP, 3, 8'h22, 1'b0, 4'hF, 4'h0);
    run_op(tag_store_pkg::OP_LOOKUP, 3, 8'h11, 1'b0, 4'hF, 4'h0);
    // Dirty upgrade, flush, then miss
    run_op(tag_store_pkg::OP_LOOKUP, 3, 8'h11, 1'b1, 4'hF, 4'h0);
    run_op(tag_store_pkg::OP_FLUSH, 3, 8'h00, 1'b0, 4'b0001, 4'h0);
    run_op(tag_store_pkg::OP_LOOKUP, 3, 8'h11, 1'b0, 4'hF, 4'h0);
    // Full set, misses rotate through the ways
    for (int i = 0; i < 10; i++)
      run_op(tag_store_pkg::OP_LOOKUP, 5, 8'h80 + i, i[0], 4'hF, 4'h0);
    // Locked and masked ways, including no eligible way
    run_op(tag_store_pkg::OP_LOOKUP, 5, 8'h89, 1'b0, 4'hF, 4'b0011);
    run_op(tag_store_pkg::OP_LOOKUP, 5, 8'h90, 1'b1, 4'b0110, 4'b0100);
    run_op(tag_store_pkg::OP_LOOKUP, 5, 8'h91, 1'b0, 4'b0011, 4'b0011);
    run_op(tag_store_pkg::OP_LOOKUP, 7, 8'h91, 1'b0, 4'b0000, 4'h0);

    // Random mix, small tag range so hits recur
    while (op_count < NUM_OPS) begin
      rnd_op   = ($urandom % 5 == 0) ? tag_store_pkg::OP_FLUSH : tag_store_pkg::OP_LOOKUP;
      rnd_lock = ($urandom % 4 == 0) ? $urandom % 16 : 4'h0;
      if (rnd_op == tag_store_pkg::OP_FLUSH) rnd_mask = 4'b0001 << ($urandom % 4);
      else rnd_mask = ($urandom % 4 == 0) ? $urandom % 16 : 4'hF;
      run_op(rnd_op, $urandom % 16, 8'h40 + ($urandom % 6), $urandom % 2, rnd_mask, rnd_lock);
    end

    if (UUT.u_assertions.fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 40 ns period
  localparam time HALF_PERIOD  = 20ns;
  localparam int  RESET_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Release lines up with the 2 ns input drive point
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

// File: verilog/tag_req_ctrl.sv
`timescale 1ns/1ps

module tag_req_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // Request side
  input  logic                             req_valid_i,
  input  tag_store_pkg::tag_op_e           req_op_i,
  input  tag_store_pkg::index_t            req_index_i,
  input  tag_store_pkg::tag_t              req_tag_i,
  input  logic                             req_dirty_i,
  input  tag_store_pkg::way_mask_t         req_way_mask_i,
  input  tag_store_pkg::way_mask_t         spm_lock_i,
  output logic                             req_ready_o,
  // Response handshake and registered response fields
  input  logic                             res_valid_o_i,
  input  logic                             res_ready_i,
  input  tag_store_pkg::way_mask_t         sel_way_i,
  input  logic                             sel_hit_i,
  input  logic                             sel_dirty_i,
  // SRAM port
  output tag_store_pkg::way_mask_t         ram_req_o,
  output tag_store_pkg::way_mask_t         ram_we_o,
  output tag_store_pkg::index_t            ram_index_o,
  output tag_store_pkg::tag_line_t         ram_wdata_o,
  // Held request towards the datapath
  output tag_store_pkg::tag_op_e           cur_op_o,
  output tag_store_pkg::tag_t              cur_tag_o,
  output tag_store_pkg::way_mask_t         elig_mask_o,
  output logic                             load_resp_o
);

  tag_store_pkg::ctrl_state_e state_q, state_d;

  // Held request
  tag_store_pkg::tag_op_e     op_q;
  tag_store_pkg::index_t      index_q;
  tag_store_pkg::tag_t        tag_q;
  logic                       dirty_q;
  tag_store_pkg::way_mask_t   elig_q;

  logic                       accept;
  logic                       res_fire;
  tag_store_pkg::way_mask_t   elig_now;

  assign req_ready_o = (state_q == tag_store_pkg::ST_IDLE);
  assign accept      = req_valid_i & req_ready_o;
  assign res_fire    = res_valid_o_i & res_ready_i;

  // Lookups skip scratchpad ways, a flush names its way directly
  assign elig_now = (req_op_i == tag_store_pkg::OP_LOOKUP) ?
                    (req_way_mask_i & ~spm_lock_i) : req_way_mask_i;

  // Request capture on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q    <= req_op_i;
      index_q <= req_index_i;
      tag_q   <= req_tag_i;
      dirty_q <= req_dirty_i;
      elig_q  <= elig_now;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= tag_store_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // FSM and SRAM strobes
  always_comb begin
    state_d     = state_q;
    load_resp_o = 1'b0;
    ram_req_o   = '0;
    ram_we_o    = '0;
    ram_index_o = index_q;
    ram_wdata_o = '0;

    unique case (state_q)
      tag_store_pkg::ST_IDLE: begin
        // Read goes out in the accept cycle, data is back one cycle later
        ram_index_o = req_index_i;
        if (accept) begin
          ram_req_o = elig_now;
          state_d   = tag_store_pkg::ST_READ;
        end
      end
      tag_store_pkg::ST_READ: begin
        // Read data and hit vector are valid here
        load_resp_o = 1'b1;
        state_d     = tag_store_pkg::ST_RESP;
      end
      tag_store_pkg::ST_RESP: begin
        if (res_fire) begin
          state_d = tag_store_pkg::ST_IDLE;
          if (op_q == tag_store_pkg::OP_FLUSH) begin
            // Flush clears the named line
            ram_req_o = sel_way_i;
            ram_we_o  = sel_way_i;
          end else if (sel_hit_i) begin
            // Dirty upgrade only when the stored line was clean
            if (dirty_q && !sel_dirty_i) begin
              ram_req_o   = sel_way_i;
              ram_we_o    = sel_way_i;
              ram_wdata_o = tag_store_pkg::tag_line_t'{valid: 1'b1, dirty: 1'b1, tag: tag_q};
            end
          end else begin
            // Miss fill, way is zero when nothing was eligible
            ram_req_o   = sel_way_i;
            ram_we_o    = sel_way_i;
            ram_wdata_o = tag_store_pkg::tag_line_t'{valid: 1'b1, dirty: dirty_q, tag: tag_q};
          end
        end
      end
      default: begin
        state_d = tag_store_pkg::ST_IDLE;
      end
    endcase
  end

  assign cur_op_o    = op_q;
  assign cur_tag_o   = tag_q;
  assign elig_mask_o = elig_q;

endmodule

// File: verilog/tag_resp_reg.sv
`timescale 1ns/1ps

module tag_resp_reg (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic                                                  load_i,
  input  tag_store_pkg::tag_op_e                                cur_op_i,
  input  tag_store_pkg::way_mask_t                              hit_i,
  input  tag_store_pkg::way_mask_t                              victim_i,
  input  tag_store_pkg::way_mask_t                              elig_mask_i,
  input  tag_store_pkg::way_mask_t                              line_valid_i,
  input  tag_store_pkg::way_mask_t                              line_dirty_i,
  input  logic [tag_store_pkg::NUM_WAYS*tag_store_pkg::TAG_W-1:0] line_tags_i,
  input  logic                                                  res_ready_i,
  output logic                                                  res_valid_o,
  output logic                                                  res_hit_o,
  output logic                                                  res_evict_o,
  output tag_store_pkg::way_mask_t                              res_way_o,
  output tag_store_pkg::tag_t                                   res_evict_tag_o,
  output logic                                                  sel_dirty_o
);

  tag_store_pkg::way_mask_t hit_first;
  tag_store_pkg::way_mask_t sel_way;
  tag_store_pkg::tag_t      sel_tag;
  tag_store_pkg::tag_t      tag_d;
  logic                     is_lookup;
  logic                     is_hit;
  logic                     sel_valid;
  logic                     sel_dirty;

  assign is_lookup = (cur_op_i == tag_store_pkg::OP_LOOKUP);
  assign is_hit    = is_lookup & (|hit_i);

  always_comb begin
    hit_first = '0;
    sel_tag   = '0;
    // Lowest hitting way keeps the way output one-hot
    for (int i = tag_store_pkg::NUM_WAYS - 1; i >= 0; i--) begin
      if (hit_i[i]) hit_first = tag_store_pkg::way_mask_t'(1) << i;
    end
    // Tag of the chosen way, AND-OR mux
    for (int i = 0; i < tag_store_pkg::NUM_WAYS; i++) begin
      if (sel_way[i]) begin
        sel_tag = sel_tag | line_tags_i[i*tag_store_pkg::TAG_W +: tag_store_pkg::TAG_W];
      end
    end
  end

  // Hit way, miss victim or flush way
  assign sel_way   = is_lookup ? (is_hit ? hit_first : victim_i) : elig_mask_i;
  assign sel_valid = |(sel_way & line_valid_i);
  assign sel_dirty = |(sel_way & line_dirty_i);
  // No tag on a hit; invalid victims report zero
  assign tag_d     = is_hit ? '0 : ((!is_lookup || sel_valid) ? sel_tag : '0);

  // Held until the handshake
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      res_valid_o     <= 1'b0;
      res_hit_o       <= 1'b0;
      res_evict_o     <= 1'b0;
      res_way_o       <= '0;
      res_evict_tag_o <= '0;
      sel_dirty_o     <= 1'b0;
    end else if (load_i) begin
      res_valid_o     <= 1'b1;
      res_hit_o       <= is_hit;
      res_evict_o     <= ~is_hit & sel_valid & sel_dirty;
      res_way_o       <= sel_way;
      res_evict_tag_o <= tag_d;
      sel_dirty_o     <= sel_dirty;
    end else if (res_valid_o && res_ready_i) begin
      res_valid_o     <= 1'b0;
    end
  end

endmodule

// File: verilog/tag_store_pkg.sv
package tag_store_pkg;

  // Cache geometry
  localparam int unsigned NUM_WAYS  = 4;
  localparam int unsigned INDEX_W   = 4;
  localparam int unsigned TAG_W     = 8;
  localparam int unsigned NUM_SETS  = 16;
  // Binary way index width, used by the round-robin pointer
  localparam int unsigned WAY_IDX_W = 2;

  // One bit per way
  typedef logic [NUM_WAYS-1:0] way_mask_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [TAG_W-1:0]    tag_t;

  // Content of one tag SRAM word
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_line_t;

  // Request operation
  typedef enum logic {
    OP_LOOKUP = 1'b0,
    OP_FLUSH  = 1'b1
  } tag_op_e;

  // Controller FSM states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_READ = 2'd1,
    ST_RESP = 2'd2
  } ctrl_state_e;

endpackage

// File: verilog/tag_store_top.sv
`timescale 1ns/1ps

module tag_store_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Request
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  tag_store_pkg::tag_op_e   req_op_i,
  input  tag_store_pkg::index_t    req_index_i,
  input  tag_store_pkg::tag_t      req_tag_i,
  input  logic                     req_dirty_i,
  input  tag_store_pkg::way_mask_t req_way_mask_i,
  // Scratchpad ways, excluded from lookups
  input  tag_store_pkg::way_mask_t spm_lock_i,
  // Response
  output logic                     res_valid_o,
  input  logic                     res_ready_i,
  output logic                     res_hit_o,
  output logic                     res_evict_o,
  output tag_store_pkg::way_mask_t res_way_o,
  output tag_store_pkg::tag_t      res_evict_tag_o
);

  tag_store_pkg::way_mask_t  ram_req;
  tag_store_pkg::way_mask_t  ram_we;
  tag_store_pkg::index_t     ram_index;
  tag_store_pkg::tag_line_t  ram_wdata;
  tag_store_pkg::tag_op_e    cur_op;
  tag_store_pkg::tag_t       cur_tag;
  tag_store_pkg::way_mask_t  elig_mask;
  logic                      load_resp;
  tag_store_pkg::way_mask_t  line_valid;
  tag_store_pkg::way_mask_t  line_dirty;
  logic [tag_store_pkg::NUM_WAYS*tag_store_pkg::TAG_W-1:0] line_tags;
  tag_store_pkg::way_mask_t  hit;
  tag_store_pkg::way_mask_t  victim;
  logic                      sel_dirty;
  logic                      victim_upd;

  // Pointer only advances on a lookup miss at response load
  assign victim_upd = load_resp & (cur_op == tag_store_pkg::OP_LOOKUP) & ~(|hit);

  tag_req_ctrl u_ctrl (
    .clk_i, .rst_n_i,
    .req_valid_i, .req_op_i, .req_index_i, .req_tag_i, .req_dirty_i, .req_way_mask_i,
    .spm_lock_i, .req_ready_o,
    .res_valid_o_i (res_valid_o), .res_ready_i,
    .sel_way_i (res_way_o), .sel_hit_i (res_hit_o), .sel_dirty_i (sel_dirty),
    .ram_req_o (ram_req), .ram_we_o (ram_we), .ram_index_o (ram_index),
    .ram_wdata_o (ram_wdata), .cur_op_o (cur_op), .cur_tag_o (cur_tag),
    .elig_mask_o (elig_mask), .load_resp_o (load_resp)
  );

  tag_way_array u_ways (
    .clk_i, .rst_n_i,
    .ram_req_i (ram_req), .ram_we_i (ram_we), .ram_index_i (ram_index),
    .ram_wdata_i (ram_wdata), .cur_tag_i (cur_tag), .elig_mask_i (elig_mask),
    .line_valid_o (line_valid), .line_dirty_o (line_dirty),
    .line_tags_o (line_tags), .hit_o (hit)
  );

  tag_victim_select u_victim (
    .clk_i, .rst_n_i,
    .elig_mask_i (elig_mask), .line_valid_i (line_valid),
    .update_i (victim_upd), .victim_o (victim)
  );

  tag_resp_reg u_resp (
    .clk_i, .rst_n_i,
    .load_i (load_resp), .cur_op_i (cur_op), .hit_i (hit), .victim_i (victim),
    .elig_mask_i (elig_mask), .line_valid_i (line_valid), .line_dirty_i (line_dirty),
    .line_tags_i (line_tags), .res_ready_i,
    .res_valid_o, .res_hit_o, .res_evict_o, .res_way_o, .res_evict_tag_o,
    .sel_dirty_o (sel_dirty)
  );

endmodule

// File: verilog/tag_victim_select.sv
`timescale 1ns/1ps

module tag_victim_select (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  tag_store_pkg::way_mask_t elig_mask_i,
  input  tag_store_pkg::way_mask_t line_valid_i,
  input  logic                     update_i,
  output tag_store_pkg::way_mask_t victim_o
);

  // Round-robin pointer, binary way index
  logic [tag_store_pkg::WAY_IDX_W-1:0] rr_q;

  tag_store_pkg::way_mask_t            free_ways;
  logic [tag_store_pkg::WAY_IDX_W-1:0] victim_idx;
  logic [tag_store_pkg::WAY_IDX_W-1:0] cand;
  logic                                use_rr;

  assign free_ways = elig_mask_i & ~line_valid_i;

  always_comb begin
    victim_o   = '0;
    victim_idx = '0;
    use_rr     = 1'b0;
    cand       = '0;
    if (|free_ways) begin
      // Lowest invalid eligible way, scan downwards so the lowest wins
      for (int i = tag_store_pkg::NUM_WAYS - 1; i >= 0; i--) begin
        if (free_ways[i]) begin
          victim_o   = tag_store_pkg::way_mask_t'(1) << i;
          victim_idx = i[tag_store_pkg::WAY_IDX_W-1:0];
        end
      end
    end else if (|elig_mask_i) begin
      // Set full, first eligible way at or after the pointer
      use_rr = 1'b1;
      for (int k = tag_store_pkg::NUM_WAYS - 1; k >= 0; k--) begin
        // Wraps modulo the way count
        cand = rr_q + k[tag_store_pkg::WAY_IDX_W-1:0];
        if (elig_mask_i[cand]) begin
          victim_o   = tag_store_pkg::way_mask_t'(1) << cand;
          victim_idx = cand;
        end
      end
    end
  end

  // Pointer moves one past the victim, only on round-robin picks
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (update_i && use_rr) begin
      rr_q <= victim_idx + 1'b1;
    end
  end

endmodule

// File: verilog/tag_way_array.sv
`timescale 1ns/1ps

module tag_way_array (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  // SRAM port from the controller
  input  tag_store_pkg::way_mask_t                              ram_req_i,
  input  tag_store_pkg::way_mask_t                              ram_we_i,
  input  tag_store_pkg::index_t                                 ram_index_i,
  input  tag_store_pkg::tag_line_t                              ram_wdata_i,
  // Held request for the compare
  input  tag_store_pkg::tag_t                                   cur_tag_i,
  input  tag_store_pkg::way_mask_t                              elig_mask_i,
  // Read data of all ways
  output tag_store_pkg::way_mask_t                              line_valid_o,
  output tag_store_pkg::way_mask_t                              line_dirty_o,
  output logic [tag_store_pkg::NUM_WAYS*tag_store_pkg::TAG_W-1:0] line_tags_o,
  output tag_store_pkg::way_mask_t                              hit_o
);

  // One line memory per way
  for (genvar w = 0; w < tag_store_pkg::NUM_WAYS; w++) begin : gen_way
    tag_store_pkg::tag_line_t mem_q [tag_store_pkg::NUM_SETS];
    tag_store_pkg::tag_line_t rdata_q;
    logic                     rd_en;
    logic                     wr_en;

    assign rd_en = ram_req_i[w] & ~ram_we_i[w];
    assign wr_en = ram_req_i[w] & ram_we_i[w];

    // All lines start invalid and clean
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        for (int s = 0; s < tag_store_pkg::NUM_SETS; s++) begin
          mem_q[s] <= '0;
        end
      end else if (wr_en) begin
        mem_q[ram_index_i] <= ram_wdata_i;
      end
    end

    // Read data capture, one cycle latency
    // Held until the next read so the response can be formed later
    always_ff @(posedge clk_i) begin
      if (rd_en) begin
        rdata_q <= mem_q[ram_index_i];
      end
    end

    assign line_valid_o[w] = rdata_q.valid;
    assign line_dirty_o[w] = rdata_q.dirty;
    assign line_tags_o[w*tag_store_pkg::TAG_W +: tag_store_pkg::TAG_W] = rdata_q.tag;

    // Tag compare on captured data
    // only eligible ways may hit
    assign hit_o[w] = elig_mask_i[w] & rdata_q.valid & (rdata_q.tag == cur_tag_i);
  end

endmodule
